//--- Bender.yml
package:
  name: alu_credit

sources:
  - files:
      - source/aluPkg.sv
      - source/aluOpIf.sv
      - source/addSubUnit.sv
      - source/logicUnit.sv
      - source/shiftUnit.sv
      - source/opQueue.sv
      - source/aluCore.sv
      - source/aluTop.sv
  - target: simulation
    files:
      - verif/aluTop_asserts.sv
      - verif/aluTb.sv

//--- source/addSubUnit.sv
`timescale 1ns/10ps
`default_nettype none

module addSubUnit import aluPkg::*;
(
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input logic subtract,
	output logic [dataWidth-1:0] sum
);

	// Carry into each nibble, slice 0 takes the subtract bit
	logic [nibbleCount-1:0] carry;

	assign carry[0] = subtract;

	for (genvar i = 0; i < nibbleCount; i++)
	begin : gNibble
		// Two's complement of b when subtracting
		logic [nibbleWidth-1:0] bSlice;

		assign bSlice = b[nibbleWidth*i +: nibbleWidth] ^ {nibbleWidth{subtract}};

		if (i < nibbleCount - 1)
		begin : gRipple
			// Carry out feeds the next slice
			assign {carry[i+1], sum[nibbleWidth*i +: nibbleWidth]} =
				{1'b0, a[nibbleWidth*i +: nibbleWidth]} + {1'b0, bSlice}
				+ (nibbleWidth+1)'(carry[i]);
		end
		else
		begin : gTop
			// Top slice, carry out dropped
			assign sum[nibbleWidth*i +: nibbleWidth] =
				a[nibbleWidth*i +: nibbleWidth] + bSlice + nibbleWidth'(carry[i]);
		end
	end

endmodule

`default_nettype wire

//--- source/aluCore.sv
`timescale 1ns/10ps
`default_nettype none

module aluCore import aluPkg::*;
(
	input logic clock,
	input logic reset,
	aluOpIf.sink op,
	input logic resultCredit,
	output logic [dataWidth-1:0] result,
	output logic resultValid
);

	// Execute register
	logic execValid;
	funcClassT execFuncClass;
	logicFuncT execLogicFunc;
	logic [dataWidth-1:0] execA;
	logic [dataWidth-1:0] execB;
	logic execCarryIn;
	logic execConstVar;
	shiftDirT execShiftDirection;
	logic [shiftWidth-1:0] execConstAmount;

	// Unit outputs
	logic [dataWidth-1:0] shiftWord;
	logic [dataWidth-1:0] sumWord;
	logic [dataWidth-1:0] logicWord;
	logic [dataWidth-1:0] setLessWord;
	logic [dataWidth-1:0] selResult;

	// Credit and flow control
	logic [resultCountWidth-1:0] resultCount;
	logic coreActive;
	logic loadResult;
	logic takeOp;

	// Result register always drains by pulse, so only credits stall
	assign loadResult = execValid && (resultCount != '0);
	// Held low until the first cycle out of reset
	assign op.ready = coreActive && (!execValid || loadResult);
	assign takeOp = op.valid && op.ready;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			coreActive <= 1'b0;
			execValid <= 1'b0;
		end
		else
		begin
			coreActive <= 1'b1;
			if (takeOp)
				execValid <= 1'b1;
			else if (loadResult)
				execValid <= 1'b0;
		end
	end

	// Operation payload
	always_ff @(posedge clock)
	begin
		if (takeOp)
		begin
			execFuncClass <= op.funcClass;
			execLogicFunc <= op.logicFunc;
			execA <= op.a;
			execB <= op.b;
			execCarryIn <= op.carryIn;
			execConstVar <= op.constVar;
			execShiftDirection <= op.shiftDirection;
			execConstAmount <= op.constAmount;
		end
	end

	// Shift amount from the low bits of a
	shiftUnit shift0 (.operand(execB), .varAmount(execA[shiftWidth-1:0]),
		.constAmount(execConstAmount), .constVar(execConstVar),
		.shiftDirection(execShiftDirection), .result(shiftWord));

	// Carry-in doubles as subtract select
	addSubUnit addSub0 (.a(execA), .b(execB), .subtract(execCarryIn), .sum(sumWord));

	logicUnit logic0 (.a(execA), .b(execB), .logicFunc(execLogicFunc), .result(logicWord));

	// Sign of the difference in bit 0
	assign setLessWord = {{(dataWidth-1){1'b0}}, sumWord[dataWidth-1]};

	always_comb
	begin
		case (execFuncClass)
			fcShift: selResult = shiftWord;
			fcSetLess: selResult = setLessWord;
			fcAddSub: selResult = sumWord;
			default: selResult = logicWord;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (loadResult)
			result <= selResult;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			resultValid <= 1'b0;
		else
			resultValid <= loadResult;
	end

	// Spend on load, refund per consumer pulse
	always_ff @(posedge clock)
	begin
		if (reset)
			resultCount <= resultCountWidth'(resultCredits);
		else if (loadResult && !resultCredit)
			resultCount <= resultCount - 1'b1;
		else if (resultCredit && !loadResult)
			resultCount <= resultCount + 1'b1;
	end

endmodule

`default_nettype wire

//--- source/aluOpIf.sv
`timescale 1ns/10ps
`default_nettype none

interface aluOpIf import aluPkg::*; ();

	// Handshake
	logic valid;
	logic ready;

	// Operation fields
	funcClassT funcClass;
	logicFuncT logicFunc;
	logic [dataWidth-1:0] a;
	logic [dataWidth-1:0] b;
	logic carryIn;
	logic constVar;
	shiftDirT shiftDirection;
	logic [shiftWidth-1:0] constAmount;

	// Queue side
	modport source (output valid, funcClass, logicFunc, a, b, carryIn, constVar,
		shiftDirection, constAmount, input ready);

	// Core side
	modport sink (input valid, funcClass, logicFunc, a, b, carryIn, constVar,
		shiftDirection, constAmount, output ready);

endinterface

`default_nettype wire

//--- source/aluPkg.sv
`default_nettype none

package aluPkg;

	// Datapath widths
	localparam int dataWidth = 32;
	localparam int shiftWidth = 5;

	// Adder is built from 4-bit slices
	localparam int nibbleWidth = 4;
	localparam int nibbleCount = dataWidth / nibbleWidth;

	// Request queue depth, equal to the upstream credit count
	localparam int reqCredits = 2;
	localparam int reqPtrWidth = $clog2(reqCredits);

	// Credits the core may spend on results after reset
	localparam int resultCredits = 4;
	localparam int resultCountWidth = $clog2(resultCredits + 1);

	// Result source, same order as the original 4:1 mux
	typedef enum logic [1:0]
	{
		fcShift = 2'd0,
		fcSetLess = 2'd1,
		fcAddSub = 2'd2,
		fcLogic = 2'd3
	} funcClassT;

	// Bitwise function select
	typedef enum logic [1:0]
	{
		lfAnd = 2'd0,
		lfOr = 2'd1,
		lfXor = 2'd2,
		lfNor = 2'd3
	} logicFuncT;

	// Shifter direction, 1 means left
	typedef enum logic
	{
		shRight = 1'b0,
		shLeft = 1'b1
	} shiftDirT;

endpackage

`default_nettype wire

//--- source/aluTop.sv
`timescale 1ns/10ps
`default_nettype none

module aluTop import aluPkg::*;
(
	input logic clock,
	input logic reset,

	// Request side
	input logic reqValid,
	input funcClassT funcClass,
	input logicFuncT logicFunc,
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input logic carryIn,
	input logic constVar,
	input shiftDirT shiftDirection,
	input logic [shiftWidth-1:0] constAmount,
	output logic reqCredit,

	// Result side
	input logic resultCredit,
	output logic [dataWidth-1:0] result,
	output logic resultValid
);

	// Queue to core link
	aluOpIf opLink ();

	opQueue queue0
	(
		.clock(clock),
		.reset(reset),
		.reqValid(reqValid),
		.funcClass(funcClass),
		.logicFunc(logicFunc),
		.a(a),
		.b(b),
		.carryIn(carryIn),
		.constVar(constVar),
		.shiftDirection(shiftDirection),
		.constAmount(constAmount),
		.reqCredit(reqCredit),
		.op(opLink.source)
	);

	aluCore core0
	(
		.clock(clock),
		.reset(reset),
		.op(opLink.sink),
		.resultCredit(resultCredit),
		.result(result),
		.resultValid(resultValid)
	);

endmodule

`default_nettype wire

//--- source/logicUnit.sv
`timescale 1ns/10ps
`default_nettype none

module logicUnit import aluPkg::*;
(
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input logicFuncT logicFunc,
	output logic [dataWidth-1:0] result
);

	// All four functions in parallel, then pick one
	logic [dataWidth-1:0] andWord;
	logic [dataWidth-1:0] orWord;
	logic [dataWidth-1:0] xorWord;

	assign andWord = a & b;
	assign orWord = a | b;
	assign xorWord = a ^ b;

	always_comb
	begin
		case (logicFunc)
			lfAnd: result = andWord;
			lfOr: result = orWord;
			lfXor: result = xorWord;
			// NOR reuses the OR term
			default: result = ~orWord;
		endcase
	end

endmodule

`default_nettype wire

//--- source/opQueue.sv
`timescale 1ns/10ps
`default_nettype none

module opQueue import aluPkg::*;
(
	input logic clock,
	input logic reset,
	input logic reqValid,
	input funcClassT funcClass,
	input logicFuncT logicFunc,
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input logic carryIn,
	input logic constVar,
	input shiftDirT shiftDirection,
	input logic [shiftWidth-1:0] constAmount,
	output logic reqCredit,
	aluOpIf.source op
);

	// One stored request
	typedef struct packed
	{
		funcClassT funcClass;
		logicFuncT logicFunc;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic carryIn;
		logic constVar;
		shiftDirT shiftDirection;
		logic [shiftWidth-1:0] constAmount;
	} opEntryT;

	opEntryT entries [reqCredits];

	// Pointers carry an extra wrap bit
	logic [reqPtrWidth:0] wrPtr;
	logic [reqPtrWidth:0] rdPtr;
	logic popEntry;
	opEntryT head;

	// Upstream only sends with a credit, so no full check
	always_ff @(posedge clock)
	begin
		if (reqValid)
			entries[wrPtr[reqPtrWidth-1:0]] <= '{funcClass: funcClass, logicFunc: logicFunc,
				a: a, b: b, carryIn: carryIn, constVar: constVar,
				shiftDirection: shiftDirection, constAmount: constAmount};
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			reqCredit <= 1'b0;
		end
		else
		begin
			if (reqValid)
				wrPtr <= wrPtr + 1'b1;
			if (popEntry)
				rdPtr <= rdPtr + 1'b1;
			// One credit back per entry that left
			reqCredit <= popEntry;
		end
	end

	// Head entry drives the interface
	assign head = entries[rdPtr[reqPtrWidth-1:0]];
	assign op.valid = (wrPtr != rdPtr);
	assign popEntry = op.valid && op.ready;

	assign op.funcClass = head.funcClass;
	assign op.logicFunc = head.logicFunc;
	assign op.a = head.a;
	assign op.b = head.b;
	assign op.carryIn = head.carryIn;
	assign op.constVar = head.constVar;
	assign op.shiftDirection = head.shiftDirection;
	assign op.constAmount = head.constAmount;

endmodule

`default_nettype wire

//--- source/shiftUnit.sv
`timescale 1ns/10ps
`default_nettype none

module shiftUnit import aluPkg::*;
(
	input logic [dataWidth-1:0] operand,
	input logic [shiftWidth-1:0] varAmount,
	input logic [shiftWidth-1:0] constAmount,
	input logic constVar,
	input shiftDirT shiftDirection,
	output logic [dataWidth-1:0] result
);

	// Selected shift amount
	logic [shiftWidth-1:0] amount;

	// Variable amount comes from operand a
	assign amount = constVar ? varAmount : constAmount;

	always_comb
	begin
		// Logical shifts, zero fill both ways
		if (shiftDirection == shLeft)
			result = operand << amount;
		else
			result = operand >> amount;
	end

endmodule

`default_nettype wire

//--- src.f
source/aluPkg.sv
source/aluOpIf.sv
source/addSubUnit.sv
source/logicUnit.sv
source/shiftUnit.sv
source/opQueue.sv
source/aluCore.sv
source/aluTop.sv
verif/aluTop_asserts.sv
verif/aluTb.sv

//--- verif/aluTb.sv
`timescale 1ns/10ps
`default_nettype none

module aluTb import aluPkg::*; ();

	// One request as the upstream sees it
	typedef struct
	{
		funcClassT funcClass;
		logicFuncT logicFunc;
		logic [dataWidth-1:0] a;
		logic [dataWidth-1:0] b;
		logic carryIn;
		logic constVar;
		shiftDirT shiftDirection;
		logic [shiftWidth-1:0] constAmount;
	} opT;

	logic clock;
	logic reset;
	logic reqValid;
	funcClassT funcClass;
	logicFuncT logicFunc;
	logic [dataWidth-1:0] a;
	logic [dataWidth-1:0] b;
	logic carryIn;
	logic constVar;
	shiftDirT shiftDirection;
	logic [shiftWidth-1:0] constAmount;
	logic reqCredit;
	logic resultCredit;
	logic [dataWidth-1:0] result;
	logic resultValid;

	integer seed = 32'he06d;
	opT opList [$];
	logic [dataWidth-1:0] expectedQ [$];
	int directedCount;
	// Credit bookkeeping on both sides
	int reqsSent = 0;
	int reqCreditsBack = 0;
	int resultsSeen = 0;
	int resultCreditsBack = 0;
	bit isolatedMode = 1'b0;
	bit withholdCredits = 1'b0;

	aluTop dut0 (.*);

	always #10 clock = ~clock;

	task automatic failRun();
		$display("Regression failed");
		$fatal(1);
	endtask

	function automatic opT makeOp(funcClassT fc, logicFuncT lf, logic [dataWidth-1:0] opA,
		logic [dataWidth-1:0] opB, logic cin, logic cv, shiftDirT dir,
		logic [shiftWidth-1:0] amount);
		opT op;
		op.funcClass = fc;
		op.logicFunc = lf;
		op.a = opA;
		op.b = opB;
		op.carryIn = cin;
		op.constVar = cv;
		op.shiftDirection = dir;
		op.constAmount = amount;
		return op;
	endfunction

	// Reference model straight from the ALU rules
	function automatic logic [dataWidth-1:0] expectedResult(opT op);
		logic [dataWidth-1:0] sum;
		logic [shiftWidth-1:0] amount;
		logic [dataWidth-1:0] value;
		// Carry-in 1 means a minus b
		sum = op.carryIn ? op.a - op.b : op.a + op.b;
		amount = op.constVar ? op.a[shiftWidth-1:0] : op.constAmount;
		case (op.funcClass)
			fcShift: value = (op.shiftDirection == shLeft) ? op.b << amount : op.b >> amount;
			fcSetLess: value = {{(dataWidth-1){1'b0}}, sum[dataWidth-1]};
			fcAddSub: value = sum;
			default:
				case (op.logicFunc)
					lfAnd: value = op.a & op.b;
					lfOr: value = op.a | op.b;
					lfXor: value = op.a ^ op.b;
					default: value = ~(op.a | op.b);
				endcase
		endcase
		return value;
	endfunction

	task automatic buildOps();
		opT op;
		// Add and subtract, wrap-around both ways
		opList.push_back(makeOp(fcAddSub, lfAnd, 32'd5, 32'd7, 1'b0, 1'b0, shRight, 5'd0));
		opList.push_back(makeOp(fcAddSub, lfAnd, 32'hffff_ffff, 32'd1, 1'b0, 1'b0, shRight, 5'd0));
		opList.push_back(makeOp(fcAddSub, lfAnd, 32'd10, 32'd3, 1'b1, 1'b0, shRight, 5'd0));
		opList.push_back(makeOp(fcAddSub, lfAnd, 32'd0, 32'd1, 1'b1, 1'b0, shRight, 5'd0));
		opList.push_back(makeOp(fcAddSub, lfOr, 32'h8000_0000, 32'h8000_0000, 1'b0, 1'b0,
			shLeft, 5'd3));
		// Set-less on a below, above and equal to b
		opList.push_back(makeOp(fcSetLess, lfAnd, 32'd3, 32'd9, 1'b1, 1'b0, shRight, 5'd0));
		opList.push_back(makeOp(fcSetLess, lfAnd, 32'd9, 32'd3, 1'b1, 1'b0, shRight, 5'd0));
		opList.push_back(makeOp(fcSetLess, lfAnd, 32'd5, 32'd5, 1'b1, 1'b0, shRight, 5'd0));
		// All four logic functions on one pair
		for (int i = 0; i < 4; i++)
			opList.push_back(makeOp(fcLogic, logicFuncT'(i), 32'hf0f0_1234, 32'h0ff0_5678,
				1'b0, 1'b0, shRight, 5'd0));
		// Shifts by constant and by a, amounts 0 and 31 included
		opList.push_back(makeOp(fcShift, lfAnd, 32'd0, 32'hdead_beef, 1'b0, 1'b0, shLeft, 5'd0));
		opList.push_back(makeOp(fcShift, lfAnd, 32'd0, 32'hdead_beef, 1'b0, 1'b0, shLeft, 5'd31));
		opList.push_back(makeOp(fcShift, lfAnd, 32'd0, 32'hdead_beef, 1'b0, 1'b0, shRight, 5'd4));
		opList.push_back(makeOp(fcShift, lfAnd, 32'd31, 32'hdead_beef, 1'b0, 1'b1, shRight,
			5'd2));
		opList.push_back(makeOp(fcShift, lfAnd, 32'h23, 32'h0000_0f0f, 1'b0, 1'b1, shLeft,
			5'd9));
		directedCount = opList.size();
		for (int i = 0; i < 48; i++)
		begin
			op.funcClass = funcClassT'($random(seed) & 3);
			op.logicFunc = logicFuncT'($random(seed) & 3);
			op.a = $random(seed);
			op.b = $random(seed);
			op.carryIn = $random(seed);
			op.constVar = $random(seed);
			op.shiftDirection = shiftDirT'($random(seed) & 1);
			op.constAmount = $random(seed);
			opList.push_back(op);
		end
	endtask

	task automatic sendOp(opT op);
		// Hold off until a request credit is free
		while (reqsSent - reqCreditsBack >= reqCredits)
			@(negedge clock);
		reqValid = 1'b1;
		funcClass = op.funcClass;
		logicFunc = op.logicFunc;
		a = op.a;
		b = op.b;
		carryIn = op.carryIn;
		constVar = op.constVar;
		shiftDirection = op.shiftDirection;
		constAmount = op.constAmount;
		expectedQ.push_back(expectedResult(op));
		reqsSent++;
		@(negedge clock);
		reqValid = 1'b0;
	endtask

	always @(posedge clock)
	begin
		if (!reset && reqCredit)
			reqCreditsBack++;
	end

	// Result credits, thinned out under back-pressure
	always @(negedge clock)
	begin
		resultCredit = 1'b0;
		if (!reset && resultCreditsBack < resultsSeen)
		begin
			if (!withholdCredits || ($random(seed) & 3) == 0)
			begin
				resultCredit = 1'b1;
				resultCreditsBack++;
			end
		end
	end

	// Value and order check against the model queue
	always @(posedge clock)
	begin
		if (!reset && resultValid)
		begin
			if (expectedQ.size() == 0)
			begin
				$display("A result arrived with no request outstanding at %0t", $time);
				failRun();
			end
			else
			begin
				assert (result === expectedQ[0])
				begin
					void'(expectedQ.pop_front());
					resultsSeen++;
				end
				else
				begin
					$display("[FAIL] time %0t: result expected %h, actual %h", $time,
						expectedQ[0], result);
					failRun();
				end
			end
		end
	end

	// Isolated request lands on the result port three edges later
	latencyCheck: assert property (@(posedge clock) disable iff (reset)
		isolatedMode && reqValid |-> ##3 resultValid)
	else
	begin
		$display("Isolated request at %0t gave no result three cycles later", $time);
		failRun();
	end

	always @(posedge clock)
	begin
		if (dut0.asserts0.failCount != 0)
		begin
			$display("A protocol assertion on the DUT ports failed");
			failRun();
		end
	end

	initial
	begin
		int limit;
		#1;
		limit = opList.size() * 20 * 20 + 16 * 20;
		#(limit);
		$display("Watchdog expired after %0d ns with results outstanding", limit);
		failRun();
	end

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		reqValid = 1'b0;
		funcClass = fcShift;
		logicFunc = lfAnd;
		a = '0;
		b = '0;
		carryIn = 1'b0;
		constVar = 1'b0;
		shiftDirection = shRight;
		constAmount = '0;
		resultCredit = 1'b0;
		buildOps();
		repeat (16) @(negedge clock);
		reset = 1'b0;
		repeat (2) @(negedge clock);
		// Directed cases one at a time, credits back at once
		isolatedMode = 1'b1;
		for (int i = 0; i < directedCount; i++)
		begin
			sendOp(opList[i]);
			while (expectedQ.size() != 0)
				@(negedge clock);
			repeat (2) @(negedge clock);
		end
		isolatedMode = 1'b0;
		// Random traffic back to back with result credits held back
		withholdCredits = 1'b1;
		for (int i = directedCount; i < opList.size(); i++)
			sendOp(opList[i]);
		while (expectedQ.size() != 0)
			@(negedge clock);
		repeat (4) @(negedge clock);
		// Every request handed its credit back once it left the queue
		if (reqCreditsBack == reqsSent)
		begin
			$display("Regression passed");
			$finish;
		end
		else
		begin
			$display("Request credits missing at the end of the run");
			failRun();
		end
	end

endmodule

`default_nettype wire

//--- verif/aluTop_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module aluTopAsserts import aluPkg::*;
(
	input logic clock,
	input logic reset,
	input logic reqValid,
	input logic reqCredit,
	input logic resultCredit,
	input logic resultValid,
	input logic [dataWidth-1:0] result
);

	// Running totals since reset
	int acceptedReqs;
	int returnedReqCredits;
	int emittedResults;
	int returnedResultCredits;
	// Polled by the testbench
	int failCount = 0;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			acceptedReqs <= 0;
			returnedReqCredits <= 0;
			emittedResults <= 0;
			returnedResultCredits <= 0;
		end
		else
		begin
			acceptedReqs <= acceptedReqs + int'(reqValid);
			returnedReqCredits <= returnedReqCredits + int'(reqCredit);
			emittedResults <= emittedResults + int'(resultValid);
			returnedResultCredits <= returnedResultCredits + int'(resultCredit);
		end
	end

	// Each result spends a credit the core actually held
	assert property (@(posedge clock) disable iff (reset)
		resultValid |-> emittedResults < resultCredits + returnedResultCredits)
	else
	begin
		$error("result emitted without a result credit");
		failCount++;
	end

	// Credit back only for an entry that came in
	assert property (@(posedge clock) disable iff (reset)
		reqCredit |-> returnedReqCredits < acceptedReqs)
	else
	begin
		$error("request credit returned with no request accepted");
		failCount++;
	end

	assert property (@(posedge clock) disable iff (reset)
		resultValid |-> !$isunknown(result))
	else
	begin
		$error("result has unknown bits while resultValid is high");
		failCount++;
	end

	// Outputs quiet under reset and in the first cycles out of it
	assert property (@(posedge clock) reset |=> !resultValid && !reqCredit)
	else
	begin
		$error("output pulse during reset");
		failCount++;
	end

	assert property (@(posedge clock) $fell(reset) |=> !resultValid && !reqCredit)
	else
	begin
		$error("output pulse right after reset");
		failCount++;
	end

endmodule

bind aluTop aluTopAsserts asserts0
(
	.clock(clock),
	.reset(reset),
	.reqValid(reqValid),
	.reqCredit(reqCredit),
	.resultCredit(resultCredit),
	.resultValid(resultValid),
	.result(result)
);

`default_nettype wire
